/* design/serpentPkg.sv */
package serpentPkg;

	//////////////////////////////////////////////////
	// widths
	//////////////////////////////////////////////////

	typedef logic [31:0] serpentWord;
	typedef logic [127:0] serpentBlock; // word 0 in the low bits
	typedef logic [255:0] serpentKey;
	typedef logic [2:0] sboxSel;
	typedef logic [5:0] roundIdx;
	typedef logic [1:0] tickCnt;

	typedef enum logic [2:0] {idle, start, round, finalRound, finish} serpentState;

	//////////////////////////////////////////////////
	// constants
	//////////////////////////////////////////////////

	// golden ratio, feeds the prekey recurrence
	parameter serpentWord PHI = 32'h9e3779b9;

	parameter logic [3:0] SBOX_TABLE [0:7][0:15] = '{
		'{4'h3, 4'h8, 4'hf, 4'h1, 4'ha, 4'h6, 4'h5, 4'hb,
			4'he, 4'hd, 4'h4, 4'h2, 4'h7, 4'h0, 4'h9, 4'hc},
		'{4'hf, 4'hc, 4'h2, 4'h7, 4'h9, 4'h0, 4'h5, 4'ha,
			4'h1, 4'hb, 4'he, 4'h8, 4'h6, 4'hd, 4'h3, 4'h4},
		'{4'h8, 4'h6, 4'h7, 4'h9, 4'h3, 4'hc, 4'ha, 4'hf,
			4'hd, 4'h1, 4'he, 4'h4, 4'h0, 4'hb, 4'h5, 4'h2},
		'{4'h0, 4'hf, 4'hb, 4'h8, 4'hc, 4'h9, 4'h6, 4'h3,
			4'hd, 4'h1, 4'h2, 4'h4, 4'ha, 4'h7, 4'h5, 4'he},
		'{4'h1, 4'hf, 4'h8, 4'h3, 4'hc, 4'h0, 4'hb, 4'h6,
			4'h2, 4'h5, 4'h4, 4'ha, 4'h9, 4'he, 4'h7, 4'hd},
		'{4'hf, 4'h5, 4'h2, 4'hb, 4'h4, 4'ha, 4'h9, 4'hc,
			4'h0, 4'h3, 4'he, 4'h8, 4'hd, 4'h6, 4'h7, 4'h1},
		'{4'h7, 4'h2, 4'hc, 4'h5, 4'h8, 4'h4, 4'h6, 4'hb,
			4'he, 4'h9, 4'h1, 4'hf, 4'hd, 4'h3, 4'ha, 4'h0},
		'{4'h1, 4'hd, 4'hf, 4'h0, 4'he, 4'h8, 4'h2, 4'hb,
			4'h7, 4'h4, 4'hc, 4'ha, 4'h9, 4'h3, 4'h5, 4'h6}
	};

	// rotate left, n is never zero here
	function automatic serpentWord rotl(serpentWord x, int unsigned n);
		return (x << n) | (x >> (32 - n));
	endfunction

endpackage

/* design/serpentSbox.sv */
`timescale 1ns/1ps

module serpentSbox
(
	input serpentPkg::sboxSel sel,
	input serpentPkg::serpentBlock in,
	output serpentPkg::serpentBlock out
);
	import serpentPkg::*;

	// bitslice form: bit i of the four words makes one nibble,
	// word 0 supplies the lsb
	always_comb
	begin
		logic [3:0] nib;
		logic [3:0] res;

		out = '0;
		for (int i = 0; i < 32; i++)
		begin
			nib = {in[96 + i], in[64 + i], in[32 + i], in[i]};
			res = SBOX_TABLE[sel][nib];
			out[i] = res[0];
			out[32 + i] = res[1];
			out[64 + i] = res[2];
			out[96 + i] = res[3]; // word 3 takes the msb
		end
	end

endmodule

/* design/serpentKeySchedule.sv */
`timescale 1ns/1ps

module serpentKeySchedule
(
	input logic clk,
	input logic rstN,
	input serpentPkg::serpentKey key,
	input logic keyLoad,
	input logic keyStep,
	input logic keyLock,
	input serpentPkg::sboxSel keySel,
	output serpentPkg::serpentBlock subkey
);
	import serpentPkg::*;

	serpentWord win [0:7]; // win[7] is the newest prekey word
	logic [7:0] idx; // counts up to 131 on a full run
	serpentWord newWord;
	serpentBlock sboxIn;
	serpentBlock sboxOut;

	//////////////////////////////////////////////////
	// prekey recurrence
	//////////////////////////////////////////////////

	// w[i] = (w[i-8] ^ w[i-5] ^ w[i-3] ^ w[i-1] ^ phi ^ i) <<< 11
	assign newWord = rotl(win[0] ^ win[3] ^ win[5] ^ win[7] ^ PHI ^ serpentWord'(idx), 11);

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			idx <= '0;
		end
		else if (keyLoad)
		begin
			idx <= '0;
		end
		else if (keyStep)
		begin
			idx <= idx + 8'd1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (keyLoad)
		begin
			for (int k = 0; k < 8; k++)
			begin
				win[k] <= key[32 * k +: 32];
			end
		end
		else if (keyStep)
		begin
			for (int k = 0; k < 7; k++)
			begin
				win[k] <= win[k + 1];
			end
			win[7] <= newWord;
		end
	end

	//////////////////////////////////////////////////
	// subkey
	//////////////////////////////////////////////////

	// four newest words, the one being computed lands in word 3
	assign sboxIn = {newWord, win[7], win[6], win[5]};

	serpentSbox keyBox
	(
		.sel(keySel),
		.in(sboxIn),
		.out(sboxOut)
	);

	always_ff @(posedge clk)
	begin
		if (keyLock)
			subkey <= sboxOut;
	end

endmodule

/* design/serpentDatapath.sv */
`timescale 1ns/1ps

module serpentDatapath
(
	input logic clk,
	input logic rstN,
	input serpentPkg::serpentBlock plaintext,
	input logic dataLoad,
	input logic roundStep,
	input logic lastRound,
	input logic whiten,
	input serpentPkg::sboxSel dataSel,
	input serpentPkg::serpentBlock subkey,
	output serpentPkg::serpentBlock ciphertext
);
	import serpentPkg::*;

	serpentBlock mixed;
	serpentBlock substituted;
	serpentBlock nextRound;

	function automatic serpentBlock linearTransform(serpentBlock b);
		serpentWord x0;
		serpentWord x1;
		serpentWord x2;
		serpentWord x3;

		x0 = rotl(b[31:0], 13);
		x2 = rotl(b[95:64], 3);
		x1 = b[63:32] ^ x0 ^ x2;
		x3 = b[127:96] ^ x2 ^ (x0 << 3);
		x1 = rotl(x1, 1);
		x3 = rotl(x3, 7);
		x0 = x0 ^ x1 ^ x3;
		x2 = x2 ^ x3 ^ (x1 << 7);
		x0 = rotl(x0, 5);
		x2 = rotl(x2, 22);
		return {x3, x2, x1, x0};
	endfunction

	assign mixed = ciphertext ^ subkey; // key mixing

	serpentSbox dataBox
	(
		.sel(dataSel),
		.in(mixed),
		.out(substituted)
	);

	// last round has no linear transform
	assign nextRound = lastRound ? substituted : linearTransform(substituted);

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			ciphertext <= '0;
		end
		else if (dataLoad)
		begin
			ciphertext <= plaintext;
		end
		else if (roundStep)
		begin
			ciphertext <= nextRound;
		end
		else if (whiten)
		begin
			ciphertext <= mixed; // xor with subkey 32
		end
	end

endmodule

/* design/serpentControl.sv */
`timescale 1ns/1ps

module serpentControl
#(
	parameter int NUM_ROUNDS = 32
)
(
	input logic clk,
	input logic rstN,
	input logic go,
	output logic keyLoad,
	output logic keyStep,
	output logic keyLock,
	output logic dataLoad,
	output logic roundStep,
	output logic lastRound,
	output logic whiten,
	output serpentPkg::sboxSel dataSel,
	output serpentPkg::sboxSel keySel,
	output logic busy,
	output logic done
);
	import serpentPkg::*;

	serpentState state;
	serpentState nextState;
	tickCnt tick;
	roundIdx roundNum;
	logic phaseEnd;
	logic inPhase;

	assign phaseEnd = (tick == 2'd3);
	assign inPhase = (state == start) || (state == round) || (state == finalRound);

	//////////////////////////////////////////////////
	// next state
	//////////////////////////////////////////////////

	always_comb
	begin
		nextState = state;
		case (state)
			idle:
			begin
				if (go)
					nextState = start;
			end
			start:
			begin
				if (phaseEnd)
					nextState = (NUM_ROUNDS > 1) ? round : finalRound;
			end
			round:
			begin
				if (phaseEnd && roundNum == roundIdx'(NUM_ROUNDS - 2))
					nextState = finalRound;
			end
			finalRound:
			begin
				if (phaseEnd)
					nextState = finish;
			end
			finish:
			begin
				nextState = idle;
			end
			default:
			begin
				nextState = idle;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= idle;
			tick <= '0;
			roundNum <= '0;
			done <= 1'b0;
		end
		else
		begin
			state <= nextState;
			done <= (state == finish); // ciphertext is whitened by then
			if (state == idle || state == finish)
				tick <= '0;
			else
				tick <= tick + 2'd1;
			if (state == idle)
				roundNum <= '0;
			else if (roundStep)
				roundNum <= roundNum + 6'd1;
		end
	end

	//////////////////////////////////////////////////
	// strobes
	//////////////////////////////////////////////////

	assign keyLoad = (state == idle) && go;
	assign dataLoad = (state == idle) && go;
	assign keyStep = inPhase; // one prekey word per cycle
	assign keyLock = inPhase && phaseEnd;
	assign roundStep = (state == round || state == finalRound) && phaseEnd;
	assign lastRound = (state == finalRound);
	assign whiten = (state == finish);
	assign busy = (state != idle);

	// data box follows the round, key box runs backwards from 3
	assign dataSel = roundNum[2:0];
	assign keySel = (state == start) ? 3'd3 : 3'd2 - roundNum[2:0];

endmodule

/* design/serpentCore.sv */
`timescale 1ns/1ps

module serpentCore
#(
	parameter int NUM_ROUNDS = 32
)
(
	input logic clk,
	input logic rstN,
	input logic go,
	input serpentPkg::serpentBlock plaintext,
	input serpentPkg::serpentKey key,
	output serpentPkg::serpentBlock ciphertext,
	output logic busy,
	output logic done
);
	import serpentPkg::*;

	logic keyLoad;
	logic keyStep;
	logic keyLock;
	logic dataLoad;
	logic roundStep;
	logic lastRound;
	logic whiten;
	sboxSel dataSel;
	sboxSel keySel;
	serpentBlock subkey;

	serpentControl #(
		.NUM_ROUNDS(NUM_ROUNDS)
	) control (
		.clk(clk),
		.rstN(rstN),
		.go(go),
		.keyLoad(keyLoad),
		.keyStep(keyStep),
		.keyLock(keyLock),
		.dataLoad(dataLoad),
		.roundStep(roundStep),
		.lastRound(lastRound),
		.whiten(whiten),
		.dataSel(dataSel),
		.keySel(keySel),
		.busy(busy),
		.done(done)
	);

	serpentKeySchedule keySchedule
	(
		.clk(clk),
		.rstN(rstN),
		.key(key),
		.keyLoad(keyLoad),
		.keyStep(keyStep),
		.keyLock(keyLock),
		.keySel(keySel),
		.subkey(subkey)
	);

	serpentDatapath datapath
	(
		.clk(clk),
		.rstN(rstN),
		.plaintext(plaintext),
		.dataLoad(dataLoad),
		.roundStep(roundStep),
		.lastRound(lastRound),
		.whiten(whiten),
		.dataSel(dataSel),
		.subkey(subkey),
		.ciphertext(ciphertext)
	);

endmodule

/* bench/serpentCore_sva.sv */
`timescale 1ns/1ps

module serpentControlSva
(
	input logic clk,
	input logic rstN,
	input logic go,
	input logic keyLock,
	input logic roundStep,
	input logic busy,
	input logic done,
	input serpentPkg::serpentState state
);
	import serpentPkg::*;

	logic goSeen; // run started and not yet finished
	logic [7:0] lockCount; // subkeys locked so far in this run

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			goSeen <= 1'b0;
		else if (go && state == idle)
			goSeen <= 1'b1;
		else if (done)
			goSeen <= 1'b0;
	end

	// the first lock of a run belongs to the start phase
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			lockCount <= '0;
		else if (go && state == idle)
			lockCount <= '0;
		else if (keyLock)
			lockCount <= lockCount + 8'd1;
	end

	strobesInRound: assert property (@(posedge clk) disable iff (!rstN)
		(keyLock && roundStep) |-> (goSeen && lockCount != '0))
		else $error("keyLock and roundStep together outside a round state");

	doneNotBusy: assert property (@(posedge clk) disable iff (!rstN) !(done && busy))
		else $error("done and busy high together");

	doneAfterGo: assert property (@(posedge clk) disable iff (!rstN) done |-> goSeen)
		else $error("done without a preceding go");

endmodule

bind serpentControl serpentControlSva controlChecks
(
	.clk(clk),
	.rstN(rstN),
	.go(go),
	.keyLock(keyLock),
	.roundStep(roundStep),
	.busy(busy),
	.done(done),
	.state(state)
);

/* bench/serpentModel.svh */
`ifndef SERPENT_MODEL_SVH
`define SERPENT_MODEL_SVH

// each box as 16 hex digits, entry 0 is the leftmost digit
localparam logic [63:0] MODEL_SBOX [0:7] = '{
	64'h38f1a65bed42709c, 64'hfc27905a1be86d34, 64'h86793cafd1e40b52, 64'h0fb8c963d124a75e,
	64'h1f83c0b6254a9e7d, 64'hf52b4a9c03e8d671, 64'h72c5846be91fd3a0, 64'h1df0e82b74ca9356
};
localparam logic [31:0] GOLDEN = 32'h9e3779b9;

function automatic logic [31:0] rotateLeft(logic [31:0] x, int n);
	logic [63:0] twice;

	twice = {x, x};
	return twice[32 - n +: 32];
endfunction

// bit i of every word forms one nibble, word 0 gives the lsb
function automatic logic [127:0] applySboxes(int box, logic [127:0] b);
	logic [127:0] r;
	logic [3:0] x;
	logic [3:0] y;

	for (int i = 0; i < 32; i++)
	begin
		x = {b[96 + i], b[64 + i], b[32 + i], b[i]};
		y = MODEL_SBOX[box][60 - 4 * int'(x) +: 4];
		{r[96 + i], r[64 + i], r[32 + i], r[i]} = y;
	end
	return r;
endfunction

function automatic logic [127:0] mixLinear(logic [127:0] b);
	logic [31:0] x [0:3];

	for (int j = 0; j < 4; j++)
		x[j] = b[32 * j +: 32];
	x[0] = rotateLeft(x[0], 13);
	x[2] = rotateLeft(x[2], 3);
	x[1] = x[1] ^ x[0] ^ x[2];
	x[3] = x[3] ^ x[2] ^ (x[0] << 3);
	x[1] = rotateLeft(x[1], 1);
	x[3] = rotateLeft(x[3], 7);
	x[0] = x[0] ^ x[1] ^ x[3];
	x[2] = x[2] ^ x[3] ^ (x[1] << 7);
	x[0] = rotateLeft(x[0], 5);
	x[2] = rotateLeft(x[2], 22);
	return {x[3], x[2], x[1], x[0]};
endfunction

// all prekey words are expanded up front, then the rounds run
function automatic logic [127:0] modelEncrypt(logic [127:0] pt, logic [255:0] userKey);
	logic [31:0] w [0:4 * NUM_ROUNDS + 11];
	logic [127:0] subkeys [0:NUM_ROUNDS];
	logic [127:0] s;

	for (int j = 0; j < 8; j++)
		w[j] = userKey[32 * j +: 32];
	for (int i = 0; i < 4 * NUM_ROUNDS + 4; i++)
		w[i + 8] = rotateLeft(w[i] ^ w[i + 3] ^ w[i + 5] ^ w[i + 7] ^ GOLDEN ^ i, 11);
	for (int r = 0; r <= NUM_ROUNDS; r++)
		subkeys[r] = applySboxes((3 - r) & 7,
			{w[4 * r + 11], w[4 * r + 10], w[4 * r + 9], w[4 * r + 8]});
	s = pt;
	for (int r = 0; r < NUM_ROUNDS; r++)
	begin
		s = applySboxes(r % 8, s ^ subkeys[r]);
		if (r < NUM_ROUNDS - 1)
			s = mixLinear(s);
	end
	return s ^ subkeys[NUM_ROUNDS]; // final whitening
endfunction

`endif

/* bench/serpentTb.sv */
`timescale 1ns/1ps

module serpentTb;
	import serpentPkg::*;

	localparam int NUM_ROUNDS = 32;
	localparam int NUM_TESTS = 200;
	localparam int CLK_PERIOD = 100;
	localparam int DONE_DELAY = 4 + 4 * NUM_ROUNDS + 1;
	localparam int WATCHDOG_CYCLES = (NUM_TESTS + 2) * 140;

	logic clk;
	logic rstN;
	logic go;
	serpentBlock plaintext;
	serpentKey key;
	serpentBlock ciphertext;
	logic busy;
	logic done;

	int seed = 32'hc398;
	serpentBlock ptVec [0:NUM_TESTS - 1];
	serpentKey keyVec [0:NUM_TESTS - 1];
	serpentBlock expVec [0:NUM_TESTS - 1];
	bit failReported = 1'b0;
	bit passed = 1'b0;
	bit chain;
	bit launched;

	`include "serpentModel.svh"

	serpentCore #(
		.NUM_ROUNDS(NUM_ROUNDS)
	) i_dut (
		.clk(clk),
		.rstN(rstN),
		.go(go),
		.plaintext(plaintext),
		.key(key),
		.ciphertext(ciphertext),
		.busy(busy),
		.done(done)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	function automatic serpentBlock randomBlock();
		serpentBlock b;

		for (int j = 0; j < 4; j++)
			b[32 * j +: 32] = $random(seed);
		return b;
	endfunction

	function automatic serpentKey randomKey();
		return {randomBlock(), randomBlock()};
	endfunction

	task automatic stopOnError(input string msg);
		$display("Fail at %0d ns: %s", $time, msg);
		failReported = 1'b1;
		$display("TEST FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	// noise while busy, the next block may be launched in the done cycle
	task automatic driveWhileBusy(input int cycle, input int n, input bit chainNext);
		if (chainNext && cycle == DONE_DELAY)
		begin
			go <= 1'b1;
			plaintext <= ptVec[n + 1];
			key <= keyVec[n + 1];
		end
		else
		begin
			go <= (cycle < DONE_DELAY - 3) && (($random(seed) & 7) == 0); // ignored go pulses
			plaintext <= randomBlock();
			key <= randomKey();
		end
	endtask

	task automatic encryptAndCheck(input int n, input bit preLaunched, input bit chainNext);
		int cycles;

		if (!preLaunched)
		begin
			@(posedge clk);
			go <= 1'b1;
			plaintext <= ptVec[n];
			key <= keyVec[n];
		end
		@(posedge clk); // go sampled here
		go <= 1'b0;
		plaintext <= randomBlock();
		key <= randomKey();
		cycles = 0;
		@(negedge clk);
		while (!done && cycles < DONE_DELAY + 5)
		begin
			assert (busy)
				else stopOnError($sformatf("test %0d busy low at cycle %0d", n, cycles));
			@(posedge clk);
			cycles++;
			driveWhileBusy(cycles, n, chainNext);
			@(negedge clk);
		end
		assert (cycles == DONE_DELAY)
			else stopOnError($sformatf("test %0d done after %0d cycles, expected %0d",
				n, cycles, DONE_DELAY));
		assert (ciphertext == expVec[n])
			else stopOnError($sformatf("test %0d ciphertext %h, expected %h",
				n, ciphertext, expVec[n]));
	endtask

	task automatic checkHold(input int n, input int idleCycles);
		repeat (idleCycles)
		begin
			@(posedge clk);
			go <= 1'b0;
			plaintext <= randomBlock();
			key <= randomKey();
			@(negedge clk);
			assert (ciphertext == expVec[n] && !busy && !done)
				else stopOnError($sformatf("test %0d outputs moved while idle", n));
		end
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial
	begin
		clk = 1'b0;
		rstN = 1'b0;
		go = 1'b0;
		plaintext = '0;
		key = '0;
		for (int n = 0; n < NUM_TESTS; n++)
		begin
			ptVec[n] = randomBlock();
			keyVec[n] = randomKey();
			expVec[n] = modelEncrypt(ptVec[n], keyVec[n]);
		end
		repeat (5) @(posedge clk);
		rstN <= 1'b1;
		repeat (3)
		begin
			@(negedge clk);
			assert (!busy && !done && ciphertext == '0)
				else stopOnError("outputs not idle after reset");
		end
		launched = 1'b0;
		for (int n = 0; n < NUM_TESTS; n++)
		begin
			chain = (n < NUM_TESTS - 1) && (($random(seed) & 3) == 0);
			encryptAndCheck(n, launched, chain);
			if (!chain)
				checkHold(n, 1 + ($random(seed) & 3));
			launched = chain;
		end
		passed = 1'b1;
		$display("TEST OK");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired because the encryptions did not finish in time");
		failReported = 1'b1;
		$display("TEST FAILED");
		$fatal(1, "watchdog timeout");
	end

	// a bound assertion may end the run without going through the checks
	final
	begin
		if (!passed && !failReported)
			$display("TEST FAILED");
	end

endmodule

/* project.f */
+incdir+bench
design/serpentPkg.sv
design/serpentSbox.sv
design/serpentKeySchedule.sv
design/serpentDatapath.sv
design/serpentControl.sv
design/serpentCore.sv
bench/serpentCore_sva.sv
bench/serpentTb.sv

/* Makefile */
.PHONY: all run clean

all: run

obj_dir/VserpentTb: project.f $(wildcard design/*.sv bench/*.sv bench/*.svh)
	verilator --binary --timing --assert --top-module serpentTb -f project.f

run: obj_dir/VserpentTb
	./obj_dir/VserpentTb 2>&1 | tee sim.log
	@if grep -q "TEST FAILED" sim.log || ! grep -q "TEST OK" sim.log; then \
		echo "simulation reported a failure"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
